//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int INST_W      = 32;
    localparam int WORD_W      = 32;
    localparam int VREG_ADDR_W = 6;
    localparam int OPCODE_W    = 7;
    localparam int FUNC3_W     = 3;
    localparam int FUNC7_W     = 7;
    localparam int NUM_VREGS   = 2 ** VREG_ADDR_W;  // Integer bank then float bank

    typedef logic [INST_W-1:0]      inst_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [VREG_ADDR_W-1:0] vreg_addr_t;    // Bit 5 picks the float bank
    typedef logic [OPCODE_W-1:0]    opcode_t;
    typedef logic [FUNC3_W-1:0]     func3_t;
    typedef logic [FUNC7_W-1:0]     func7_t;

    localparam opcode_t OP_ALU    = 7'b0110011;
    localparam opcode_t OP_ALUI   = 7'b0010011;
    localparam opcode_t OP_FPU    = 7'b1010011;
    localparam opcode_t OP_MEML   = 7'b0000011;
    localparam opcode_t OP_MEMS   = 7'b0100011;
    localparam opcode_t OP_FMEML  = 7'b0000111;
    localparam opcode_t OP_FMEMS  = 7'b0100111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_INPUT  = 7'b0001011;  // Custom-0
    localparam opcode_t OP_OUTPUT = 7'b0101011;  // Custom-1

    typedef enum logic [2:0] {
        EXEC_ALU    = 3'd0,
        EXEC_FPU    = 3'd1,
        EXEC_MEM    = 3'd2,
        EXEC_JUMP   = 3'd3,
        EXEC_BRANCH = 3'd4,
        EXEC_SUBST  = 3'd5,
        EXEC_IO     = 3'd6,
        EXEC_NONE   = 3'd7
    } exec_type_e;

    typedef struct packed {
        exec_type_e exec_type;
        logic       alu_imm;
        logic       alu_ext;   // Register ALU op with func7[0] set
        logic       is_float;
    } exec_info_t;

    // Raw class flags from the decoder, before priority resolution
    typedef struct packed {
        logic alu;
        logic fpu;
        logic mem;
        logic jump;
        logic branch;
        logic subst;
        logic io;
        logic alu_imm;
        logic alu_ext;
        logic is_float;
    } class_flags_t;

    typedef struct packed {
        exec_info_t info;
        vreg_addr_t va_rs1;
        vreg_addr_t va_rs2;
        vreg_addr_t va_rd;
        word_t      imm;
        opcode_t    opcode;
        func3_t     func3;
        func7_t     func7;
        word_t      rs1_data;
        word_t      rs2_data;
    } decoded_t;

endpackage

`default_nettype wire

//--- hdl/decode.sv
`default_nettype none

module decode (
    input  wire core_pkg::inst_t       instr,
    input  wire core_pkg::word_t       pc,
    output core_pkg::vreg_addr_t       va_rs1,
    output core_pkg::vreg_addr_t       va_rs2,
    output core_pkg::vreg_addr_t       va_rd,
    output core_pkg::word_t            imm,
    output core_pkg::opcode_t          opcode,
    output core_pkg::func3_t           func3,
    output core_pkg::func7_t           func7,
    output core_pkg::class_flags_t     class_flags
);

    import core_pkg::*;

    logic  is_alu;
    logic  is_fpu;
    logic  is_mem;
    logic  is_jump;
    logic  is_branch;
    logic  is_subst;
    logic  is_io;
    logic  is_float;
    logic  rs1_float;
    logic  rs2_float;
    logic  rd_float;
    logic  no_use_rd;
    logic  no_use_rs1;
    logic  no_use_rs2;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    word_t imm_u;

    assign opcode = instr[6:0];
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];

    assign is_alu    = (opcode == OP_ALU) | (opcode == OP_ALUI);
    assign is_fpu    = (opcode == OP_FPU);
    assign is_mem    = (opcode == OP_MEML) | (opcode == OP_MEMS)
                     | (opcode == OP_FMEML) | (opcode == OP_FMEMS);
    assign is_jump   = (opcode == OP_JAL) | (opcode == OP_JALR);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_subst  = (opcode == OP_LUI) | (opcode == OP_AUIPC);
    assign is_io     = (opcode == OP_INPUT) | (opcode == OP_OUTPUT);
    assign is_float  = is_fpu
                     | (opcode == OP_FMEML) | (opcode == OP_FMEMS)
                     | (is_io & func7[5]);  // Float I/O variant

    // Conversions and moves cross banks, selected by func7[6] and func7[4:3]
    assign rs1_float = is_float & ~is_mem
                     & (~func7[6] | (func7[3] ^ func7[4]) | is_io);
    assign rs2_float = is_float;
    assign rd_float  = is_float
                     & (is_mem | ~func7[6] | ~(func7[3] ^ func7[4]) | is_io);

    assign no_use_rd  = (opcode == OP_MEMS) | (opcode == OP_FMEMS)
                      | (opcode == OP_OUTPUT) | (opcode == OP_BRANCH);
    assign no_use_rs1 = (opcode == OP_LUI) | (opcode == OP_JAL)
                      | (opcode == OP_AUIPC) | (opcode == OP_INPUT);
    assign no_use_rs2 = ~((opcode == OP_ALU) | (opcode == OP_BRANCH)
                      | (opcode == OP_MEMS) | (opcode == OP_FMEMS)
                      | (is_fpu & ~func7[5]));  // Single-source FPU ops have bit 5 set

    assign va_rd  = no_use_rd  ? '0 : {rd_float,  instr[11:7]};
    assign va_rs1 = no_use_rs1 ? '0 : {rs1_float, instr[19:15]};
    assign va_rs2 = no_use_rs2 ? '0 : {rs2_float, instr[24:20]};

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        case (opcode)
            OP_MEMS,
            OP_FMEMS:  imm = imm_s;
            OP_BRANCH: imm = imm_b + pc;  // Branch target resolved here
            OP_JAL:    imm = imm_j + pc;
            OP_LUI:    imm = imm_u;
            OP_AUIPC:  imm = imm_u + pc;
            default:   imm = imm_i;
        endcase
    end

    always_comb begin
        class_flags          = '0;
        class_flags.alu      = is_alu;
        class_flags.fpu      = is_fpu;
        class_flags.mem      = is_mem;
        class_flags.jump     = is_jump;
        class_flags.branch   = is_branch;
        class_flags.subst    = is_subst;
        class_flags.io       = is_io;
        class_flags.alu_imm  = (opcode == OP_ALUI);
        class_flags.alu_ext  = (opcode == OP_ALU) & func7[0];
        class_flags.is_float = is_float;
    end

endmodule

`default_nettype wire

//--- hdl/pack_exec_type.sv
`default_nettype none

module pack_exec_type (
    input  wire core_pkg::class_flags_t class_flags,
    output core_pkg::exec_info_t        info
);

    import core_pkg::*;

    exec_type_e exec_type;

    // First raised flag wins, io ahead of everything else
    always_comb begin
        if (class_flags.io) begin
            exec_type = EXEC_IO;
        end else if (class_flags.fpu) begin
            exec_type = EXEC_FPU;
        end else if (class_flags.mem) begin
            exec_type = EXEC_MEM;
        end else if (class_flags.jump) begin
            exec_type = EXEC_JUMP;
        end else if (class_flags.branch) begin
            exec_type = EXEC_BRANCH;
        end else if (class_flags.subst) begin
            exec_type = EXEC_SUBST;
        end else if (class_flags.alu) begin
            exec_type = EXEC_ALU;
        end else begin
            exec_type = EXEC_NONE;  // Unknown opcode
        end
    end

    always_comb begin
        info.exec_type = exec_type;
        info.alu_imm   = class_flags.alu_imm;
        info.alu_ext   = class_flags.alu_ext;
        info.is_float  = class_flags.is_float;
    end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`default_nettype none

module reg_file (
    input  wire                       clk,
    input  wire                       reset,
    input  wire core_pkg::vreg_addr_t rs1_addr,
    input  wire core_pkg::vreg_addr_t rs2_addr,
    output core_pkg::word_t           rs1_data,
    output core_pkg::word_t           rs2_data,
    input  wire                       wb_en,
    input  wire core_pkg::vreg_addr_t wb_addr,
    input  wire core_pkg::word_t      wb_data
);

    import core_pkg::*;

    word_t regs [NUM_VREGS];
    logic  wr_ok;

    assign wr_ok = wb_en & (wb_addr != '0);  // Integer x0 is never written

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_VREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Shared read path for both ports
    function automatic word_t read_port(input vreg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr_ok && wb_addr == addr) begin
            value = wb_data;  // Same-cycle writeback bypass
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

//--- hdl/operand_stage.sv
`default_nettype none

module operand_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     instr_valid,
    input  wire                     hold,
    input  wire core_pkg::decoded_t d,
    output core_pkg::decoded_t      out,
    output logic                    out_valid
);

    import core_pkg::*;

    logic advance;
    logic capture;

    assign advance = ~hold;                // Execute side is ready for the next item
    assign capture = advance & instr_valid;

    // Valid tracks the strobe whenever the stage is allowed to move
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= instr_valid;
        end
    end

    // Payload only changes on a real capture, so a bubble keeps the old content
    always_ff @(posedge clk) begin
        if (reset) begin
            out <= '0;
        end else if (capture) begin
            out.info     <= d.info;
            out.va_rs1   <= d.va_rs1;
            out.va_rs2   <= d.va_rs2;
            out.va_rd    <= d.va_rd;
            out.imm      <= d.imm;
            out.opcode   <= d.opcode;
            out.func3    <= d.func3;
            out.func7    <= d.func7;
            out.rs1_data <= d.rs1_data;
            out.rs2_data <= d.rs2_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       instr_valid,
    input  wire core_pkg::inst_t      instr,
    input  wire core_pkg::word_t      pc,
    input  wire                       hold,
    input  wire                       wb_en,
    input  wire core_pkg::vreg_addr_t wb_addr,
    input  wire core_pkg::word_t      wb_data,
    output core_pkg::decoded_t        out,
    output logic                      out_valid
);

    import core_pkg::*;

    vreg_addr_t   va_rs1;
    vreg_addr_t   va_rs2;
    vreg_addr_t   va_rd;
    word_t        imm;
    opcode_t      opcode;
    func3_t       func3;
    func7_t       func7;
    class_flags_t class_flags;
    exec_info_t   info;
    word_t        rs1_data;
    word_t        rs2_data;
    decoded_t     dec;

    decode u_decode (
        .instr       (instr),
        .pc          (pc),
        .va_rs1      (va_rs1),
        .va_rs2      (va_rs2),
        .va_rd       (va_rd),
        .imm         (imm),
        .opcode      (opcode),
        .func3       (func3),
        .func7       (func7),
        .class_flags (class_flags)
    );

    pack_exec_type u_pack_exec_type (
        .class_flags (class_flags),
        .info        (info)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (va_rs1),
        .rs2_addr (va_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

    always_comb begin
        dec.info     = info;
        dec.va_rs1   = va_rs1;
        dec.va_rs2   = va_rs2;
        dec.va_rd    = va_rd;
        dec.imm      = imm;
        dec.opcode   = opcode;
        dec.func3    = func3;
        dec.func7    = func7;
        dec.rs1_data = rs1_data;  // Operands read in the same cycle as decode
        dec.rs2_data = rs2_data;
    end

    operand_stage u_operand_stage (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .hold        (hold),
        .d           (dec),
        .out         (out),
        .out_valid   (out_valid)
    );

endmodule

`default_nettype wire

//--- verif/decode_vectors.svh
// Columns: instruction, pc, exec type, {alu_imm, alu_ext, is_float}, rs1, rs2, rd, imm, bypass
// A bypass row writes fresh data to its rs1 address in the issue cycle
add_row('h002081B3, 'h0100, EXEC_ALU,    'b000, 'h01, 'h02, 'h03, 'h00000002, 0);  // add
add_row('h027302B3, 'h0104, EXEC_ALU,    'b010, 'h06, 'h07, 'h05, 'h00000027, 1);  // mul
add_row('hFFB48413, 'h0108, EXEC_ALU,    'b100, 'h09, 'h00, 'h08, 'hFFFFFFFB, 0);
add_row('h7FF00513, 'h010C, EXEC_ALU,    'b100, 'h00, 'h00, 'h0A, 'h000007FF, 0);  // Reads x0
add_row('hFF062583, 'h0110, EXEC_MEM,    'b000, 'h0C, 'h00, 'h0B, 'hFFFFFFF0, 0);
add_row('h02D72223, 'h0114, EXEC_MEM,    'b000, 'h0E, 'h0D, 'h00, 'h00000024, 0);
add_row('hFEF82E23, 'h0118, EXEC_MEM,    'b000, 'h10, 'h0F, 'h00, 'hFFFFFFFC, 0);
add_row('h0088A087, 'h011C, EXEC_MEM,    'b001, 'h11, 'h00, 'h21, 'h00000008, 0);  // flw
add_row('h00292627, 'h0120, EXEC_MEM,    'b001, 'h12, 'h22, 'h00, 'h0000000C, 0);  // fsw
add_row('h005201D3, 'h0124, EXEC_FPU,    'b001, 'h24, 'h25, 'h23, 'h00000005, 1);
add_row('h10838353, 'h0128, EXEC_FPU,    'b001, 'h27, 'h28, 'h26, 'h00000108, 0);
add_row('h580504D3, 'h012C, EXEC_FPU,    'b001, 'h2A, 'h00, 'h29, 'h00000580, 0);  // fsqrt
add_row('h010000EF, 'h1000, EXEC_JUMP,   'b000, 'h00, 'h00, 'h01, 'h00001010, 0);
add_row('hFF9FF06F, 'h2000, EXEC_JUMP,   'b000, 'h00, 'h00, 'h00, 'h00001FF8, 0);
add_row('h004280E7, 'h0130, EXEC_JUMP,   'b000, 'h05, 'h00, 'h01, 'h00000004, 0);  // jalr
add_row('h00730863, 'h0300, EXEC_BRANCH, 'b000, 'h06, 'h07, 'h00, 'h00000310, 0);
add_row('hFE9410E3, 'h0400, EXEC_BRANCH, 'b000, 'h08, 'h09, 'h00, 'h000003E0, 0);
add_row('hABCDEA37, 'h0134, EXEC_SUBST,  'b000, 'h00, 'h00, 'h14, 'hABCDE000, 0);  // lui
add_row('h00001A97, 'h0500, EXEC_SUBST,  'b000, 'h00, 'h00, 'h15, 'h00001500, 0);
add_row('hFFFFFB17, 'h3000, EXEC_SUBST,  'b000, 'h00, 'h00, 'h16, 'h00002000, 0);
add_row('h00000B8B, 'h0138, EXEC_IO,     'b000, 'h00, 'h00, 'h17, 'h00000000, 0);
add_row('h4000058B, 'h013C, EXEC_IO,     'b001, 'h00, 'h00, 'h2B, 'h00000400, 0);
add_row('h000C002B, 'h0140, EXEC_IO,     'b000, 'h18, 'h00, 'h00, 'h00000000, 0);
add_row('h4006002B, 'h0144, EXEC_IO,     'b001, 'h2C, 'h00, 'h00, 'h00000400, 0);
add_row('h0000007F, 'h0148, EXEC_NONE,   'b000, 'h00, 'h00, 'h00, 'h00000000, 0);

//--- verif/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import core_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int SEED       = 82732;

    typedef struct packed {
        inst_t      instr;
        word_t      pc;
        exec_type_e etype;
        logic [2:0] flags;     // alu_imm, alu_ext, is_float
        vreg_addr_t rs1;
        vreg_addr_t rs2;
        vreg_addr_t rd;
        word_t      imm;
        logic       bypass;
    } row_t;

    logic       clk;
    logic       reset;
    logic       instr_valid;
    inst_t      instr;
    word_t      pc;
    logic       hold;
    logic       wb_en;
    vreg_addr_t wb_addr;
    word_t      wb_data;
    decoded_t   out;
    logic       out_valid;

    row_t  rows[$];
    int    num_rows = 0;
    int    errors = 0;
    int    checks = 0;
    word_t shadow [NUM_VREGS];  // Expected register contents

    decode_stage u_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .hold        (hold),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .out         (out),
        .out_valid   (out_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic add_row(input inst_t i_w, input word_t pc_w, input exec_type_e etype,
                           input logic [2:0] flags, input vreg_addr_t rs1,
                           input vreg_addr_t rs2, input vreg_addr_t rd,
                           input word_t imm, input logic bypass);
        row_t r;
        r.instr  = i_w;
        r.pc     = pc_w;
        r.etype  = etype;
        r.flags  = flags;
        r.rs1    = rs1;
        r.rs2    = rs2;
        r.rd     = rd;
        r.imm    = imm;
        r.bypass = bypass;
        rows.push_back(r);
    endtask

    task automatic load_table;
        `include "decode_vectors.svh"
        num_rows = rows.size();
    endtask

    task automatic compare_value(input string name, input logic [159:0] got,
                                 input logic [159:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    // x0 reads zero, and a same-cycle write to the read address shows through
    function automatic word_t expect_read(input vreg_addr_t addr, input logic byp,
                                          input vreg_addr_t byp_addr, input word_t byp_data);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (byp && addr == byp_addr) begin
            value = byp_data;
        end else begin
            value = shadow[addr];
        end
        return value;
    endfunction

    task automatic check_row(input int idx, input row_t r, input word_t exp_rs1,
                             input word_t exp_rs2);
        string tag;
        tag = $sformatf("row %0d ", idx);
        compare_value({tag, "out_valid"}, out_valid, 1'b1);
        compare_value({tag, "exec_type"}, out.info.exec_type, r.etype);
        compare_value({tag, "alu_imm"}, out.info.alu_imm, r.flags[2]);
        compare_value({tag, "alu_ext"}, out.info.alu_ext, r.flags[1]);
        compare_value({tag, "is_float"}, out.info.is_float, r.flags[0]);
        compare_value({tag, "va_rs1"}, out.va_rs1, r.rs1);
        compare_value({tag, "va_rs2"}, out.va_rs2, r.rs2);
        compare_value({tag, "va_rd"}, out.va_rd, r.rd);
        compare_value({tag, "imm"}, out.imm, r.imm);
        compare_value({tag, "opcode"}, out.opcode, r.instr[6:0]);
        compare_value({tag, "func3"}, out.func3, r.instr[14:12]);
        compare_value({tag, "func7"}, out.func7, r.instr[31:25]);
        compare_value({tag, "rs1_data"}, out.rs1_data, exp_rs1);
        compare_value({tag, "rs2_data"}, out.rs2_data, exp_rs2);
    endtask

    initial begin
        wait (num_rows > 0);
        #((num_rows + 20) * CLK_PERIOD * 4);
        $display("Watchdog timeout: the stimulus did not finish in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int unsigned seed_state;
        row_t        r;
        word_t       byp_data;
        word_t       exp_rs1;
        word_t       exp_rs2;
        decoded_t    held;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = '0;
        hold        = 1'b0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        seed_state  = $urandom(SEED);
        load_table();

        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        compare_value("out_valid after reset", out_valid, 1'b0);
        compare_value("out after reset", out, '0);

        // Both banks get random values, and the write to address 0 must not stick
        for (int a = 0; a < NUM_VREGS; a++) begin
            wb_en     = 1'b1;
            wb_addr   = vreg_addr_t'(a);
            wb_data   = $urandom();
            shadow[a] = (a == 0) ? '0 : wb_data;
            next_cycle();
        end
        wb_en = 1'b0;

        for (int i = 0; i < num_rows; i++) begin
            r           = rows[i];
            instr       = r.instr;
            pc          = r.pc;
            instr_valid = 1'b1;
            byp_data    = $urandom();
            if (r.bypass) begin
                wb_en   = 1'b1;
                wb_addr = r.rs1;
                wb_data = byp_data;
            end
            exp_rs1 = expect_read(r.rs1, r.bypass, r.rs1, byp_data);
            exp_rs2 = expect_read(r.rs2, r.bypass, r.rs1, byp_data);
            next_cycle();
            if (r.bypass) begin
                shadow[r.rs1] = byp_data;
            end
            wb_en = 1'b0;
            check_row(i, r, exp_rs1, exp_rs2);
            instr_valid = 1'b0;
            next_cycle();
            compare_value($sformatf("row %0d out_valid after strobe", i), out_valid, 1'b0);
        end

        instr       = rows[2].instr;
        pc          = rows[2].pc;
        instr_valid = 1'b1;
        next_cycle();
        held = out;
        compare_value("out_valid before hold", out_valid, 1'b1);
        compare_value("out.imm before hold", held.imm, rows[2].imm);
        hold  = 1'b1;
        instr = rows[5].instr;  // Dropped while the stage is held
        pc    = rows[5].pc;
        repeat (3) begin
            next_cycle();
            compare_value("out_valid during hold", out_valid, 1'b1);
            compare_value("out during hold", out, held);
            instr_valid = 1'b0;  // A held stage keeps its valid without a strobe
        end
        hold = 1'b0;
        next_cycle();
        compare_value("out_valid after hold", out_valid, 1'b0);
        compare_value("out after hold", out, held);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
hdl/core_pkg.sv
hdl/decode.sv
hdl/pack_exec_type.sv
hdl/reg_file.sv
hdl/operand_stage.sv
hdl/decode_stage.sv
+incdir+verif
verif/decode_stage_tb.sv
